// File: include/sad_cfg.svh
`ifndef SAD_CFG_SVH
`define SAD_CFG_SVH

// signed sample width
`define SAD_PIX_W 8

// one guard bit so a difference of two samples never wraps
`define SAD_DIFF_W (`SAD_PIX_W + 1)

// block sum, wraps modulo 2**SAD_ACC_W
`define SAD_ACC_W 16

`endif

// File: hw/sad_pkg.sv
`include "sad_cfg.svh"

package sad_pkg;

    // one input sample, two's complement
    typedef logic signed [`SAD_PIX_W-1:0] pixel_t;

    // absolute difference of two samples, always fits unsigned
    typedef logic [`SAD_PIX_W-1:0] diff_t;

    // running and final block sum
    typedef logic [`SAD_ACC_W-1:0] sad_t;

endpackage

// File: hw/kogge_stone_adder.sv
`include "sad_cfg.svh"

module kogge_stone_adder #(
    parameter int width = `SAD_DIFF_W
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width-1:0] sum
);

    // number of prefix levels, span doubles per level
    localparam int levels = $clog2(width);

    logic [width-1:0] p_bit;
    logic [width-1:0] g_bit;
    logic [width-1:0] g_acc;
    logic [width-1:0] p_acc;
    logic [width-1:0] g_nxt;
    logic [width-1:0] p_nxt;
    logic [width-1:0] carry;

    // bitwise generate and propagate
    assign g_bit = a & b;
    assign p_bit = a ^ b;

    // prefix tree
    // after level k, bit i covers bits i down to i - 2**(k+1) + 1
    always_comb begin
        g_acc = g_bit;
        p_acc = p_bit;
        g_nxt = g_bit;
        p_nxt = p_bit;
        for (int lvl = 0; lvl < levels; lvl++) begin
            g_nxt = g_acc;
            p_nxt = p_acc;
            for (int i = (1 << lvl); i < width; i++) begin
                g_nxt[i] = g_acc[i] | (p_acc[i] & g_acc[i - (1 << lvl)]);
                p_nxt[i] = p_acc[i] & p_acc[i - (1 << lvl)];
            end
            g_acc = g_nxt;
            p_acc = p_nxt;
        end
    end

    // carry into bit i is the group generate of bits i-1 .. 0
    // carry-in is zero
    assign carry[0] = 1'b0;

    genvar i;
    generate
        for (i = 1; i < width; i++) begin : gen_carry
            assign carry[i] = g_acc[i-1];
        end
    endgenerate

    assign sum = p_bit ^ carry;

endmodule

// File: hw/abs_diff_lane.sv
`include "sad_cfg.svh"

module abs_diff_lane (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sample_valid,
    input  logic            sample_last,
    input  sad_pkg::pixel_t cur,
    input  sad_pkg::pixel_t ref_pix,
    output sad_pkg::diff_t  diff,
    output logic            diff_valid,
    output logic            diff_last
);

    logic [`SAD_DIFF_W-1:0] cur_ext;
    logic [`SAD_DIFF_W-1:0] ref_ext;
    logic [`SAD_DIFF_W-1:0] neg_cur;
    logic [`SAD_DIFF_W-1:0] neg_ref;
    logic [`SAD_DIFF_W-1:0] diff_fwd;
    logic [`SAD_DIFF_W-1:0] diff_rev;
    sad_pkg::diff_t         abs_val;

    // sign extend by one bit so cur - ref cannot overflow
    assign cur_ext = {cur[`SAD_PIX_W-1], cur};
    assign ref_ext = {ref_pix[`SAD_PIX_W-1], ref_pix};

    // two's complement negation
    assign neg_cur = ~cur_ext + 1'b1;
    assign neg_ref = ~ref_ext + 1'b1;

    // cur - ref
    kogge_stone_adder #(
        .width(`SAD_DIFF_W)
    ) u_add_fwd (
        .a  (cur_ext),
        .b  (neg_ref),
        .sum(diff_fwd)
    );

    // ref - cur
    kogge_stone_adder #(
        .width(`SAD_DIFF_W)
    ) u_add_rev (
        .a  (ref_ext),
        .b  (neg_cur),
        .sum(diff_rev)
    );

    // sign of cur - ref picks the non-negative one
    // magnitude is at most 255, so the low bits are exact
    assign abs_val = diff_fwd[`SAD_DIFF_W-1] ? diff_rev[`SAD_PIX_W-1:0]
                                             : diff_fwd[`SAD_PIX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            diff_valid <= 1'b0;
            diff_last  <= 1'b0;
        end else begin
            diff_valid <= sample_valid;
            diff_last  <= sample_valid & sample_last;
        end
    end

    // payload only loads on a valid pair
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            diff <= abs_val;
        end
    end

endmodule

// File: hw/sad_accumulator.sv
`include "sad_cfg.svh"

module sad_accumulator (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           diff_valid,
    input  logic           diff_last,
    input  sad_pkg::diff_t diff_a,
    input  sad_pkg::diff_t diff_b,
    output sad_pkg::sad_t  sad,
    output logic           done
);

    localparam int ext_w = `SAD_ACC_W - `SAD_PIX_W;

    sad_pkg::sad_t acc;
    sad_pkg::sad_t pair_sum;
    sad_pkg::sad_t total;

    // both lanes of the current pair, zero extended
    assign pair_sum = {{ext_w{1'b0}}, diff_a} + {{ext_w{1'b0}}, diff_b};

    // block total including this pair, wraps at SAD_ACC_W
    assign total = acc + pair_sum;

    // running sum
    // cleared on last so the next block can start right away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (diff_valid) begin
            if (diff_last) begin
                acc <= '0;
            end else begin
                acc <= total;
            end
        end
    end

    // result holds until the next block closes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sad <= '0;
        end else if (diff_valid && diff_last) begin
            sad <= total;
        end
    end

    // one cycle pulse per finished block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= diff_valid & diff_last;
        end
    end

endmodule

// File: hw/sad_engine.sv
module sad_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sample_valid,
    input  logic            sample_last,
    input  sad_pkg::pixel_t cur_a,
    input  sad_pkg::pixel_t ref_a,
    input  sad_pkg::pixel_t cur_b,
    input  sad_pkg::pixel_t ref_b,
    output sad_pkg::sad_t   sad,
    output logic            done
);

    sad_pkg::diff_t diff_a;
    sad_pkg::diff_t diff_b;
    logic           diff_valid;
    logic           diff_last;

    abs_diff_lane lane_a (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample_last (sample_last),
        .cur         (cur_a),
        .ref_pix     (ref_a),
        .diff        (diff_a),
        .diff_valid  (diff_valid),
        .diff_last   (diff_last)
    );

    // same strobes as lane a, its copies are not needed
    abs_diff_lane lane_b (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample_last (sample_last),
        .cur         (cur_b),
        .ref_pix     (ref_b),
        .diff        (diff_b),
        .diff_valid  (),
        .diff_last   ()
    );

    sad_accumulator acc0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .diff_valid(diff_valid),
        .diff_last (diff_last),
        .diff_a    (diff_a),
        .diff_b    (diff_b),
        .sad       (sad),
        .done      (done)
    );

endmodule

// File: verif/sad_checker.sv
module sad_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sample_valid,
    input  logic            sample_last,
    input  sad_pkg::pixel_t cur_a,
    input  sad_pkg::pixel_t ref_a,
    input  sad_pkg::pixel_t cur_b,
    input  sad_pkg::pixel_t ref_b,
    input  sad_pkg::sad_t   sad,
    input  logic            done,
    output int              errors,
    output int              checked,
    output int              pending,
    output logic            open_block
);

    sad_pkg::sad_t exp_sum_q[$];
    int            exp_cycle_q[$];
    sad_pkg::sad_t run_sum;
    sad_pkg::sad_t held_sad;
    int            cycle;

    // reference |cur - ref| on full integers
    function automatic int abs_diff(input sad_pkg::pixel_t c, input sad_pkg::pixel_t r);
        int d;
        d = int'(c) - int'(r);
        if (d < 0) begin
            d = -d;
        end
        return d;
    endfunction

    always @(posedge clk) begin
        sad_pkg::sad_t exp_sad;
        int            due;
        if (!rst_n) begin
            exp_sum_q.delete();
            exp_cycle_q.delete();
            run_sum    = '0;
            held_sad   = '0;
            cycle      = 0;
            errors     = 0;
            checked    = 0;
            pending    = 0;
            open_block = 1'b0;
        end else begin
            cycle = cycle + 1;
            // outputs seen here come from earlier edges
            if (done) begin
                if (exp_sum_q.size() == 0) begin
                    $display("done pulsed at cycle %0d with no block outstanding", cycle);
                    errors++;
                end else begin
                    exp_sad = exp_sum_q.pop_front();
                    due     = exp_cycle_q.pop_front();
                    checked++;
                    if (due != cycle) begin
                        $display("done came at cycle %0d, expected at cycle %0d", cycle, due);
                        errors++;
                    end
                    if (sad !== exp_sad) begin
                        $display("MISMATCH sad: got 0x%h, expected 0x%h", sad, exp_sad);
                        errors++;
                    end
                    held_sad = exp_sad;
                end
            end else begin
                if (exp_cycle_q.size() != 0 && exp_cycle_q[0] < cycle) begin
                    $display("done missing, block was due at cycle %0d", exp_cycle_q[0]);
                    errors++;
                    exp_sad = exp_sum_q.pop_front();
                    due     = exp_cycle_q.pop_front();
                end
                // sad holds between blocks, zero before the first one
                if (sad !== held_sad) begin
                    $display("MISMATCH sad: got 0x%h, expected 0x%h", sad, held_sad);
                    errors++;
                end
            end
            // pair sampled at this edge
            if (sample_valid) begin
                run_sum    = run_sum + sad_pkg::sad_t'(abs_diff(cur_a, ref_a) +
                                                       abs_diff(cur_b, ref_b));
                open_block = 1'b1;
                if (sample_last) begin
                    exp_sum_q.push_back(run_sum);
                    exp_cycle_q.push_back(cycle + 2);
                    run_sum    = '0;
                    open_block = 1'b0;
                end
            end
            pending = exp_sum_q.size();
        end
    end

endmodule

// File: verif/sad_engine_tb.sv
module sad_engine_tb;

    localparam int clk_period   = 40;
    localparam int drive_dly    = 5;
    localparam int reset_cycles = 8;
    localparam int n_rand       = 40;
    localparam int n_single     = 20;
    localparam int n_wrap_pairs = 200;
    localparam int exp_blocks   = n_rand + 3 + n_single + 1;

    // worst case length of each test in cycles, drain included
    localparam int len_reset   = reset_cycles + 10;
    localparam int len_random  = n_rand * 16 * 2 + 4;
    localparam int len_extreme = 10;
    localparam int len_single  = n_single + 4;
    localparam int len_wrap    = n_wrap_pairs + 4;
    localparam int cycle_limit =
        2 * (len_reset + len_random + len_extreme + len_single + len_wrap) + 50;

    localparam sad_pkg::pixel_t pix_max  = 8'h7F;
    localparam sad_pkg::pixel_t pix_min  = 8'h80;
    localparam sad_pkg::pixel_t pix_zero = 8'h00;
    localparam sad_pkg::pixel_t pix_neg1 = 8'hFF;

    logic            clk;
    logic            rst_n;
    logic            sample_valid;
    logic            sample_last;
    sad_pkg::pixel_t cur_a;
    sad_pkg::pixel_t ref_a;
    sad_pkg::pixel_t cur_b;
    sad_pkg::pixel_t ref_b;
    sad_pkg::sad_t   sad;
    logic            done;

    int          errors;
    int          checked;
    int          pending;
    logic        open_block;
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          tb_errors;
    int          test_count;
    int          err_mark;
    int          chk_mark;

    sad_engine dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample_last (sample_last),
        .cur_a       (cur_a),
        .ref_a       (ref_a),
        .cur_b       (cur_b),
        .ref_b       (ref_b),
        .sad         (sad),
        .done        (done)
    );

    sad_checker chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample_last (sample_last),
        .cur_a       (cur_a),
        .ref_a       (ref_a),
        .cur_b       (cur_b),
        .ref_b       (ref_b),
        .sad         (sad),
        .done        (done),
        .errors      (errors),
        .checked     (checked),
        .pending     (pending),
        .open_block  (open_block)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run exceeded %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic sad_pkg::pixel_t rand_pixel();
        return sad_pkg::pixel_t'(rand_bits(8));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic send_pair(input sad_pkg::pixel_t ca, input sad_pkg::pixel_t ra,
                             input sad_pkg::pixel_t cb, input sad_pkg::pixel_t rb,
                             input logic last);
        sample_valid = 1'b1;
        sample_last  = last;
        cur_a        = ca;
        ref_a        = ra;
        cur_b        = cb;
        ref_b        = rb;
        next_cycle();
        sample_valid = 1'b0;
        sample_last  = 1'b0;
    endtask

    task automatic drain();
        next_cycle();
        while (pending != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        if (open_block) begin
            $display("block left unfinished at the end of test %s", name);
            tb_errors++;
        end
        test_count++;
        $display("test %0d %s: %0d blocks checked, %0d errors", test_count, name,
                 checked - chk_mark, errors + tb_errors - err_mark);
        chk_mark = checked;
        err_mark = errors + tb_errors;
    endtask

    initial begin
        int pairs;
        int total;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_last  = 1'b0;
        cur_a        = '0;
        ref_a        = '0;
        cur_b        = '0;
        ref_b        = '0;
        lfsr_state   = 32'd81197;
        cycle_count  = 0;
        tb_errors    = 0;
        test_count   = 0;
        err_mark     = 0;
        chk_mark     = 0;
        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;

        // idle, checker expects done low and sad zero
        repeat (10) next_cycle();
        finish_test("reset_idle");

        for (int blk = 0; blk < n_rand; blk++) begin
            pairs = int'(rand_bits(4)) + 1;
            for (int p = 0; p < pairs; p++) begin
                if (rand_bits(2) == 0) begin
                    next_cycle();
                end
                send_pair(rand_pixel(), rand_pixel(), rand_pixel(), rand_pixel(),
                          p == pairs - 1);
            end
        end
        drain();
        finish_test("random_blocks");

        send_pair(pix_max, pix_min, pix_max, pix_min, 1'b1);
        send_pair(pix_min, pix_max, pix_min, pix_max, 1'b1);
        send_pair(pix_max, pix_min, pix_min, pix_max, 1'b0);
        send_pair(pix_min, pix_min, pix_max, pix_max, 1'b0);
        send_pair(pix_zero, pix_min, pix_max, pix_zero, 1'b0);
        send_pair(pix_neg1, pix_max, pix_min, pix_zero, 1'b1);
        drain();
        finish_test("extreme_samples");

        for (int s = 0; s < n_single; s++) begin
            send_pair(rand_pixel(), rand_pixel(), rand_pixel(), rand_pixel(), 1'b1);
        end
        drain();
        finish_test("single_pair_blocks");

        // 510 per pair, well past 16 bits
        for (int p = 0; p < n_wrap_pairs; p++) begin
            send_pair(pix_max, pix_min, pix_min, pix_max, p == n_wrap_pairs - 1);
        end
        drain();
        finish_test("sum_wrap");

        if (checked != exp_blocks) begin
            $display("expected %0d finished blocks, saw %0d", exp_blocks, checked);
            tb_errors++;
        end
        total = errors + tb_errors;
        $display("%0d tests, %0d blocks checked, %0d errors", test_count, checked, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sad_engine.f
+incdir+include
hw/sad_pkg.sv
hw/kogge_stone_adder.sv
hw/abs_diff_lane.sv
hw/sad_accumulator.sv
hw/sad_engine.sv
verif/sad_checker.sv
verif/sad_engine_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = sad_engine_tb
FILELIST  = sad_engine.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation passed" $(LOG); then \
		echo "run: pass"; \
	else \
		echo "run: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
